// File: all.f
hdl/cpuPkg.sv
hdl/decodeAlu.sv
hdl/decodeMem.sv
hdl/decodeRegs.sv
hdl/decodeImm.sv
hdl/decodeStage.sv
bench/decodeStageTb.sv

// File: bench/decodeStageTb.sv
// Decode stage testbench
// Directed tests for the ALU class, memory decode, register fields,
// immediates and back-to-back strobes. Expected results are worked out
// here from the instruction set rules and compared with the registered outputs

`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;
	import cpuPkg::*;

	localparam int Xlen = 64;
	localparam int TimeoutCycles = 20;

	// Every defined opcode except SYS and R2
	// Indices 0..8 hold the immediate ALU group and 9..11 the misc group
	// Indices 12..20 hold the loads, 21..25 the stores and 26..35 the rest
	localparam opcode_t AluOps [36] = '{
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_ANDI, OP_ORI, OP_EORI, OP_SLTI,
		OP_SHIFT, OP_CSR, OP_MOV,
		OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_LDX,
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STX,
		OP_PFXA, OP_PFXB, OP_PFXC, OP_NOP, OP_PUSH, OP_POP, OP_ENTER, OP_LEAVE,
		OP_ATOM, OP_FENCE
	};

	// The 21 defined R2 operations
	localparam func_t FuncCodes [21] = '{
		FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU, FN_DIVU,
		FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND, FN_NOR, FN_ENOR, FN_ORC,
		FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU
	};

	logic clk;
	logic rstN;
	logic instrValid;
	instruction_t instr;
	logic decValid;
	logic isAlu;
	logic isLoad;
	logic isStore;
	logic memSigned;
	logic writesRt;
	logic illegal;
	memSize_t memSize;
	regNum_t rt;
	regNum_t ra;
	regNum_t rb;
	logic [Xlen-1:0] imm;
	int errors;

	decodeStage #(
		.Xlen(Xlen)
	) u_dut (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.decValid(decValid), .isAlu(isAlu), .isLoad(isLoad), .isStore(isStore),
		.memSigned(memSigned), .writesRt(writesRt), .illegal(illegal),
		.memSize(memSize), .rt(rt), .ra(ra), .rb(rb), .imm(imm)
	);

	always #2 clk = ~clk;

	// ========================================================================
	// Expected results from the instruction set rules
	// ========================================================================

	function automatic logic knownFunc(func_t fn);
		logic hit;
		hit = 1'b0;
		for (int k = 0; k < 21; k++)
			if (FuncCodes[k] == fn)
				hit = 1'b1;
		return hit;
	endfunction

	function automatic logic knownOpcode(opcode_t op);
		logic hit;
		hit = (op == OP_SYS) || (op == OP_R2);
		for (int k = 0; k < 36; k++)
			if (AluOps[k] == op)
				hit = 1'b1;
		return hit;
	endfunction

	// System calls stay out of the ALU and R2 needs a defined function
	function automatic logic usesAlu(instruction_t w);
		if (w.r2.opcode == OP_SYS)
			return 1'b0;
		if (w.r2.opcode == OP_R2)
			return knownFunc(w.r2.func);
		return knownOpcode(w.r2.opcode);
	endfunction

	function automatic logic loadsMem(opcode_t op);
		case (op)
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_LDX:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic storesMem(opcode_t op);
		case (op)
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STX:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Size follows the mnemonic letter and everything else is an octa
	function automatic memSize_t sizeOf(opcode_t op);
		case (op)
			OP_LDB, OP_LDBU, OP_STB:
				return SZ_BYTE;
			OP_LDW, OP_LDWU, OP_STW:
				return SZ_WYDE;
			OP_LDT, OP_LDTU, OP_STT:
				return SZ_TETRA;
			default:
				return SZ_OCTA;
		endcase
	endfunction

	// Opcodes that use the ALU slot but never write their target
	function automatic logic skipsWrite(opcode_t op);
		case (op)
			OP_NOP, OP_PFXA, OP_PFXB, OP_PFXC, OP_PUSH, OP_ENTER, OP_LEAVE,
			OP_ATOM, OP_FENCE:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic [Xlen-1:0] extendImm(instruction_t w);
		logic [Xlen-1:0] v;
		logic [20:0] f;
		logic sx;
		logic zx;
		f = w.imm.imm;
		zx = (w.imm.opcode == OP_ANDI) || (w.imm.opcode == OP_ORI) ||
			(w.imm.opcode == OP_EORI);
		sx = !zx && usesAlu(w) && w.imm.opcode != OP_R2 &&
			((w.imm.opcode == OP_ATOM) || !skipsWrite(w.imm.opcode)) &&
			w.imm.opcode != OP_POP && w.imm.opcode != OP_SYS;
		for (int b = 0; b < Xlen; b++)
			v[b] = (b < 21) ? f[b] : (sx && f[20]);
		if (!sx && !zx)
			v = '0;
		return v;
	endfunction

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic checkBit(string name, string what, logic exp, logic act);
		if (act !== exp)
		begin
			$display("Error %s: %s expected %0b actual %0b", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic checkReg(string name, string what, regNum_t exp, regNum_t act);
		if (act !== exp)
		begin
			$display("Error %s: %s expected %0d actual %0d", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic checkSize(string name, memSize_t exp, memSize_t act);
		if (act !== exp)
		begin
			$display("Error %s: memSize expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic checkImm(string name, logic [Xlen-1:0] exp, logic [Xlen-1:0] act);
		if (act !== exp)
		begin
			$display("Error %s: imm expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Compares every registered output with what the word should decode to
	task automatic compareOutputs(string name, instruction_t w);
		logic alu;
		logic st;
		opcode_t op;
		op = w.r2.opcode;
		alu = usesAlu(w);
		st = storesMem(op);
		checkBit(name, "isAlu", alu, isAlu);
		checkBit(name, "isLoad", loadsMem(op), isLoad);
		checkBit(name, "isStore", st, isStore);
		checkBit(name, "memSigned", op == OP_LDB || op == OP_LDW || op == OP_LDT, memSigned);
		checkSize(name, sizeOf(op), memSize);
		checkReg(name, "rt", w.r2.rt, rt);
		checkReg(name, "ra", w.r2.ra, ra);
		checkReg(name, "rb", (op == OP_R2) ? w.r2.rb : regNum_t'(0), rb);
		checkBit(name, "writesRt", alu && !st && !skipsWrite(op) && w.r2.rt != 0, writesRt);
		checkBit(name, "illegal",
			!knownOpcode(op) || (op == OP_R2 && !knownFunc(w.r2.func)), illegal);
		checkImm(name, extendImm(w), imm);
	endtask

	// ========================================================================
	// Stimulus helpers
	// ========================================================================

	function automatic regNum_t randReg();
		return regNum_t'($urandom % 64);
	endfunction

	function automatic logic [20:0] randField();
		return 21'($urandom);
	endfunction

	function automatic instruction_t makeR2(func_t fn, regNum_t t, regNum_t a, regNum_t b);
		instruction_t w;
		w.r2.opcode = OP_R2;
		w.r2.rt = t;
		w.r2.ra = a;
		w.r2.rb = b;
		w.r2.rc = randReg();
		w.r2.resv = 2'b00;
		w.r2.func = fn;
		return w;
	endfunction

	function automatic instruction_t makeImm(opcode_t op, regNum_t t, regNum_t a,
		logic [20:0] f);
		instruction_t w;
		w.imm.opcode = op;
		w.imm.rt = t;
		w.imm.ra = a;
		w.imm.imm = f;
		return w;
	endfunction

	// Strobes one word, waits for its pulse and compares the result
	task automatic decodeOne(string name, instruction_t w);
		int cycles;
		@(negedge clk);
		instr = w;
		instrValid = 1'b1;
		@(negedge clk);
		instrValid = 1'b0;
		cycles = 0;
		while (!decValid && cycles < TimeoutCycles)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!decValid)
		begin
			$display("Timeout in %s: decValid did not rise within %0d cycles", name,
				TimeoutCycles);
			errors++;
		end
		else
			compareOutputs(name, w);
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic resetTest();
		@(negedge clk);
		checkBit("reset", "decValid", 1'b0, decValid);
		checkBit("reset", "isAlu", 1'b0, isAlu);
		checkBit("reset", "isLoad", 1'b0, isLoad);
		checkBit("reset", "isStore", 1'b0, isStore);
		checkBit("reset", "memSigned", 1'b0, memSigned);
		checkBit("reset", "writesRt", 1'b0, writesRt);
		checkBit("reset", "illegal", 1'b0, illegal);
		checkReg("reset", "rt", 6'd0, rt);
		checkReg("reset", "ra", 6'd0, ra);
		checkReg("reset", "rb", 6'd0, rb);
		checkImm("reset", '0, imm);
	endtask

	task automatic aluClassTest();
		instruction_t w;
		for (int k = 0; k < 21; k++)
			decodeOne("aluR2", makeR2(FuncCodes[k], randReg(), randReg(), randReg()));
		for (int k = 0; k < 36; k++)
			decodeOne("aluOpcode", makeImm(AluOps[k], randReg(), randReg(), randField()));
		decodeOne("aluSys", makeImm(OP_SYS, randReg(), randReg(), randField()));
		// Function code 0 and opcode 1 are both unassigned
		w = makeR2(FN_ADD, randReg(), randReg(), randReg());
		w.r2.func = func_t'(7'd0);
		decodeOne("aluBadFunc", w);
		w = makeImm(OP_ADDI, randReg(), randReg(), randField());
		w.imm.opcode = opcode_t'(7'd1);
		decodeOne("aluBadOpcode", w);
	endtask

	task automatic memoryTest();
		for (int k = 12; k < 26; k++)
			decodeOne("memory", makeImm(AluOps[k], randReg(), randReg(), randField()));
		decodeOne("memoryNone", makeImm(OP_MOV, randReg(), randReg(), randField()));
	endtask

	task automatic registerTest();
		decodeOne("regsR2", makeR2(FN_SUB, randReg(), randReg(), randReg()));
		decodeOne("regsAddi", makeImm(OP_ADDI, 6'd5, randReg(), randField()));
		decodeOne("regsStore", makeImm(OP_STB, 6'd9, randReg(), randField()));
		decodeOne("regsNop", makeImm(OP_NOP, 6'd17, randReg(), randField()));
		decodeOne("regsPop", makeImm(OP_POP, 6'd33, randReg(), randField()));
		decodeOne("regsZero", makeImm(OP_ADDI, 6'd0, randReg(), randField()));
	endtask

	task automatic immediateTest();
		logic [20:0] f;
		f = randField();
		decodeOne("immAddiNeg", makeImm(OP_ADDI, randReg(), randReg(), f | 21'h100000));
		decodeOne("immAddiPos", makeImm(OP_ADDI, randReg(), randReg(), f & 21'h0FFFFF));
		decodeOne("immOriNeg", makeImm(OP_ORI, randReg(), randReg(), f | 21'h100000));
		decodeOne("immOriPos", makeImm(OP_ORI, randReg(), randReg(), f & 21'h0FFFFF));
		decodeOne("immR2", makeR2(FN_OR, randReg(), randReg(), randReg()));
	endtask

	// Three strobes in a row where each pulse must carry its own word
	task automatic pipelineTest();
		instruction_t seq [3];
		seq[0] = makeImm(OP_ADDI, randReg(), randReg(), randField());
		seq[1] = makeR2(FN_MUL, randReg(), randReg(), randReg());
		seq[2] = makeImm(OP_LDB, randReg(), randReg(), randField());
		@(negedge clk);
		instr = seq[0];
		instrValid = 1'b1;
		for (int k = 1; k < 3; k++)
		begin
			@(negedge clk);
			checkBit("pipeline", "decValid", 1'b1, decValid);
			compareOutputs("pipeline", seq[k-1]);
			instr = seq[k];
		end
		@(negedge clk);
		instrValid = 1'b0;
		checkBit("pipeline", "decValid", 1'b1, decValid);
		compareOutputs("pipeline", seq[2]);
		// A new word without its strobe must leave the held results alone
		instr = makeR2(FN_ADD, randReg(), randReg(), randReg());
		@(negedge clk);
		checkBit("pipeline", "decValid", 1'b0, decValid);
		compareOutputs("pipelineHold", seq[2]);
	endtask

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		errors = 0;
		void'($urandom(57045));
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		resetTest();
		aluClassTest();
		memoryTest();
		registerTest();
		immediateTest();
		pipelineTest();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
// Instruction decode stage
// Runs the ALU, memory, register and immediate decoders side by side on one
// 40-bit word and registers all their results behind the valid strobe, so
// a decoded word appears one clock after instrValid with a one-cycle decValid

`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
	parameter int Xlen = 64
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 instrValid,
	input  cpuPkg::instruction_t instr,
	output logic                 decValid,
	output logic                 isAlu,
	output logic                 isLoad,
	output logic                 isStore,
	output logic                 memSigned,
	output logic                 writesRt,
	output logic                 illegal,
	output cpuPkg::memSize_t     memSize,
	output cpuPkg::regNum_t      rt,
	output cpuPkg::regNum_t      ra,
	output cpuPkg::regNum_t      rb,
	output logic [Xlen-1:0]      imm
);
	import cpuPkg::*;

	// ========================================================================
	// Combinational decoders
	// ========================================================================

	logic isAluDec;
	logic isLoadDec;
	logic isStoreDec;
	logic memSignedDec;
	logic writesRtDec;
	logic illegalDec;
	memSize_t memSizeDec;
	regNum_t rtDec;
	regNum_t raDec;
	regNum_t rbDec;
	logic [Xlen-1:0] immDec;

	decodeAlu uAlu (
		.instr(instr),
		.isAlu(isAluDec)
	);

	decodeMem uMem (
		.instr(instr),
		.isLoad(isLoadDec),
		.isStore(isStoreDec),
		.memSize(memSizeDec),
		.memSigned(memSignedDec)
	);

	// Write enable needs the ALU and store class from the other two decoders
	decodeRegs uRegs (
		.instr(instr),
		.isAlu(isAluDec),
		.isStore(isStoreDec),
		.rt(rtDec),
		.ra(raDec),
		.rb(rbDec),
		.writesRt(writesRtDec),
		.illegal(illegalDec)
	);

	decodeImm #(
		.Xlen(Xlen)
	) uImm (
		.instr(instr),
		.imm(immDec)
	);

	// ========================================================================
	// Output register
	// ========================================================================

	// Results load on each strobe and hold until the next one
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			decValid <= 1'b0;
			isAlu <= 1'b0;
			isLoad <= 1'b0;
			isStore <= 1'b0;
			memSigned <= 1'b0;
			writesRt <= 1'b0;
			illegal <= 1'b0;
			memSize <= SZ_BYTE;
			rt <= '0;
			ra <= '0;
			rb <= '0;
			imm <= '0;
		end
		else
		begin
			// One pulse per strobe, back-to-back strobes give back-to-back pulses
			decValid <= instrValid;
			if (instrValid)
			begin
				isAlu <= isAluDec;
				isLoad <= isLoadDec;
				isStore <= isStoreDec;
				memSigned <= memSignedDec;
				writesRt <= writesRtDec;
				illegal <= illegalDec;
				memSize <= memSizeDec;
				rt <= rtDec;
				ra <= raDec;
				rb <= rbDec;
				imm <= immDec;
			end
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// The load and store opcode groups do not overlap
	loadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(isLoad && isStore))
		else $error("decoded word is both a load and a store");

	// A pulse only ever follows a strobe by exactly one clock
	validFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
		decValid |-> $past(instrValid))
		else $error("decValid without an instrValid in the previous cycle");

	// The register decoder and the ALU decoder must agree on undefined words
	illegalNotAlu: assert property (@(posedge clk) disable iff (!rstN)
		illegal |-> !isAlu)
		else $error("illegal instruction classified as ALU");

endmodule

`default_nettype wire

// File: hdl/decodeImm.sv
// Immediate decoder
// Extends the 21-bit immediate field to the machine width, by sign or by
// zero depending on the opcode, and gives zero where there is no immediate

`timescale 1ns/1ps
`default_nettype none

module decodeImm #(
	parameter int Xlen = 64
) (
	input  cpuPkg::instruction_t instr,
	output logic [Xlen-1:0]      imm
);
	import cpuPkg::*;

	logic [ImmW-1:0] field;
	logic signExt;
	logic zeroExt;

	assign field = instr.imm.imm;

	always_comb
	begin
		signExt = 1'b0;
		zeroExt = 1'b0;
		case (instr.imm.opcode)
			// Logic immediates take the field as an unsigned mask
			OP_ANDI, OP_ORI, OP_EORI:
				zeroExt = 1'b1;
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_SLTI:
				signExt = 1'b1;
			// Load and store displacements are signed
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_LDA, OP_LDX,
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STX:
				signExt = 1'b1;
			OP_SHIFT, OP_CSR, OP_MOV, OP_ATOM:
				signExt = 1'b1;
			// R2 and everything else carries no immediate
			default:
				signExt = 1'b0;
		endcase
	end

	// Top bit of the field is replicated across the upper word for signed use
	assign imm = signExt ? {{(Xlen-ImmW){field[ImmW-1]}}, field} :
		zeroExt ? {{(Xlen-ImmW){1'b0}}, field} : '0;

endmodule

`default_nettype wire

// File: hdl/decodeRegs.sv
// Register field decoder
// Pulls the register numbers out of the word, decides whether the target
// register is written and flags undefined instructions

`timescale 1ns/1ps
`default_nettype none

module decodeRegs (
	input  cpuPkg::instruction_t instr,
	input  logic                 isAlu,
	input  logic                 isStore,
	output cpuPkg::regNum_t      rt,
	output cpuPkg::regNum_t      ra,
	output cpuPkg::regNum_t      rb,
	output logic                 writesRt,
	output logic                 illegal
);
	import cpuPkg::*;

	logic noWrite;
	logic opKnown;
	logic isR2;

	// Rt and Ra sit in the same place in both formats
	assign rt = instr.r2.rt;
	assign ra = instr.r2.ra;

	// The immediate format has no Rb, its bits belong to the immediate
	assign isR2 = (instr.r2.opcode == OP_R2);
	assign rb = isR2 ? instr.r2.rb : '0;

	always_comb
	begin
		noWrite = 1'b0;
		opKnown = 1'b1;
		case (instr.r2.opcode)
			// Opcodes that go through the ALU but leave Rt alone
			OP_NOP, OP_PFXA, OP_PFXB, OP_PFXC, OP_PUSH,
			OP_ENTER, OP_LEAVE, OP_ATOM, OP_FENCE:
				noWrite = 1'b1;
			OP_SYS, OP_R2, OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI, OP_SHIFT, OP_CSR, OP_MOV,
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO,
			OP_LDA, OP_LDX, OP_STB, OP_STW, OP_STT, OP_STO, OP_STX, OP_POP:
				opKnown = 1'b1;
			default:
				opKnown = 1'b0;
		endcase
	end

	// Writes to register 0 are dropped since it always reads as zero
	assign writesRt = isAlu && !isStore && !noWrite && (rt != '0);

	// An R2 word is also illegal when its function code is undefined
	assign illegal = !opKnown || (isR2 && !funcDefined(instr.r2.func));

endmodule

`default_nettype wire

// File: hdl/decodeMem.sv
// Memory access decoder
// Classifies loads and stores and reports the access size and whether a
// loaded value is sign-extended

`timescale 1ns/1ps
`default_nettype none

module decodeMem (
	input  cpuPkg::instruction_t instr,
	output logic                 isLoad,
	output logic                 isStore,
	output cpuPkg::memSize_t     memSize,
	output logic                 memSigned
);
	import cpuPkg::*;

	always_comb
	begin
		// Non-memory opcodes report an octa with both flags low
		isLoad = 1'b0;
		isStore = 1'b0;
		memSize = SZ_OCTA;
		memSigned = 1'b0;
		case (instr.r2.opcode)
			// Only the plain B, W and T loads sign-extend
			OP_LDB:
			begin
				isLoad = 1'b1;
				memSize = SZ_BYTE;
				memSigned = 1'b1;
			end
			OP_LDBU:
			begin
				isLoad = 1'b1;
				memSize = SZ_BYTE;
			end
			OP_LDW:
			begin
				isLoad = 1'b1;
				memSize = SZ_WYDE;
				memSigned = 1'b1;
			end
			OP_LDWU:
			begin
				isLoad = 1'b1;
				memSize = SZ_WYDE;
			end
			OP_LDT:
			begin
				isLoad = 1'b1;
				memSize = SZ_TETRA;
				memSigned = 1'b1;
			end
			OP_LDTU:
			begin
				isLoad = 1'b1;
				memSize = SZ_TETRA;
			end
			// Full-width loads, the address and indexed forms included
			OP_LDO, OP_LDA, OP_LDX:
				isLoad = 1'b1;
			OP_STB:
			begin
				isStore = 1'b1;
				memSize = SZ_BYTE;
			end
			OP_STW:
			begin
				isStore = 1'b1;
				memSize = SZ_WYDE;
			end
			OP_STT:
			begin
				isStore = 1'b1;
				memSize = SZ_TETRA;
			end
			OP_STO, OP_STX:
				isStore = 1'b1;
			default:
				isLoad = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/decodeAlu.sv
// ALU class decoder
// Flags every instruction that needs the integer ALU, which includes
// address generation for loads and stores and the stack frame helpers

`timescale 1ns/1ps
`default_nettype none

module decodeAlu (
	input  cpuPkg::instruction_t instr,
	output logic                 isAlu
);
	import cpuPkg::*;

	always_comb
	begin
		case (instr.r2.opcode)
			// System calls run outside the ALU
			OP_SYS:
				isAlu = 1'b0;
			// R2 operations depend on the function code
			OP_R2:
				isAlu = funcDefined(instr.r2.func);
			// Immediate arithmetic, logic and compare
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI:
				isAlu = 1'b1;
			OP_SHIFT, OP_CSR, OP_MOV:
				isAlu = 1'b1;
			// Loads need the adder for the effective address
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_LDA, OP_LDX:
				isAlu = 1'b1;
			// Stores likewise
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STX:
				isAlu = 1'b1;
			// Prefixes and NOP pass through the ALU slot as no-ops
			OP_PFXA, OP_PFXB, OP_PFXC, OP_NOP:
				isAlu = 1'b1;
			// Stack pointer updates for frame handling
			OP_PUSH, OP_POP, OP_ENTER, OP_LEAVE:
				isAlu = 1'b1;
			OP_ATOM, OP_FENCE:
				isAlu = 1'b1;
			// anything else is an undefined opcode
			default:
				isAlu = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/cpuPkg.sv
// CPU decode package
// Encodings of the primary opcode, the R2 function code and the memory
// access size, plus the two instruction formats that the decode stage
// reads out of the same 40-bit word

`default_nettype none

package cpuPkg;

	// ========================================================================
	// Field types
	// ========================================================================

	// Width of the immediate field in the immediate format
	localparam int ImmW = 21;

	// Register numbers index a 64-entry file, register 0 always reads as zero
	typedef logic [5:0] regNum_t;

	// ========================================================================
	// Encodings
	// ========================================================================

	// Primary opcode in the low seven bits of every instruction
	// Codes that are not listed are undefined and decode as illegal
	typedef enum logic [6:0] {
		OP_SYS = 7'd0, OP_R2 = 7'd2,
		OP_ADDI = 7'd4, OP_SUBFI = 7'd5, OP_CMPI = 7'd6, OP_MULI = 7'd7,
		OP_ANDI = 7'd8, OP_ORI = 7'd9, OP_EORI = 7'd10, OP_SLTI = 7'd11,
		OP_DIVI = 7'd13,
		OP_SHIFT = 7'd16, OP_CSR = 7'd19, OP_MOV = 7'd20,
		// Loads, the unsigned forms sit on the odd codes
		OP_LDB = 7'd64, OP_LDBU = 7'd65, OP_LDW = 7'd66, OP_LDWU = 7'd67,
		OP_LDT = 7'd68, OP_LDTU = 7'd69, OP_LDO = 7'd70, OP_LDA = 7'd74,
		OP_LDX = 7'd79,
		// Stores
		OP_STB = 7'd80, OP_STW = 7'd81, OP_STT = 7'd82, OP_STO = 7'd83,
		OP_STX = 7'd87,
		// Prefixes, stack frame and system housekeeping
		OP_PFXA = 7'd112, OP_PFXB = 7'd113, OP_PFXC = 7'd114,
		OP_PUSH = 7'd116, OP_POP = 7'd117, OP_ENTER = 7'd118, OP_LEAVE = 7'd119,
		OP_ATOM = 7'd122, OP_FENCE = 7'd123, OP_NOP = 7'd127
	} opcode_t;

	// Function code of the R2 format, top seven bits of the word
	typedef enum logic [6:0] {
		FN_ADD = 7'd4, FN_CMP = 7'd5, FN_MUL = 7'd6, FN_DIV = 7'd7,
		FN_SUB = 7'd8, FN_MULU = 7'd14, FN_DIVU = 7'd15,
		FN_AND = 7'd16, FN_OR = 7'd17, FN_EOR = 7'd18, FN_ANDC = 7'd19,
		FN_NAND = 7'd20, FN_NOR = 7'd21, FN_ENOR = 7'd22, FN_ORC = 7'd23,
		// Set-on-condition group
		FN_SEQ = 7'd24, FN_SNE = 7'd25, FN_SLT = 7'd26, FN_SLE = 7'd27,
		FN_SLTU = 7'd28, FN_SLEU = 7'd29
	} func_t;

	// Access size of a load or store, byte up to octa (8 bytes)
	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_WYDE = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA = 2'd3
	} memSize_t;

	// ========================================================================
	// Instruction formats
	// ========================================================================

	// Register format, fields listed from the top bit down
	typedef struct packed {
		func_t func;
		logic [1:0] resv;
		regNum_t rc;
		regNum_t rb;
		regNum_t ra;
		regNum_t rt;
		opcode_t opcode;
	} instrR2_t;

	// Immediate format, opcode Rt and Ra line up with the register format
	typedef struct packed {
		logic [ImmW-1:0] imm;
		regNum_t ra;
		regNum_t rt;
		opcode_t opcode;
	} instrImm_t;

	// One 40-bit word seen through either format
	typedef union packed {
		instrR2_t r2;
		instrImm_t imm;
	} instruction_t;

	// True when an R2 function code is one of the defined operations
	function automatic logic funcDefined(func_t fn);
		case (fn)
			FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU, FN_DIVU,
			FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND, FN_NOR, FN_ENOR, FN_ORC,
			FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
				funcDefined = 1'b1;
			default:
				funcDefined = 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire
